// File: verilog.f
rtl/la_pkg.sv
rtl/la_cfg_regs.sv
rtl/la_trigger.sv
rtl/la_ctrl.sv
rtl/la_sample_buf.sv
rtl/la_tx_serial.sv
rtl/la_top.sv
testbench/la_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module la_tb -o la_sim

out=$(./obj_dir/la_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi

// File: testbench/la_tb.sv
// testbench for la_top that runs a table of capture runs and checks the serialized readout bytes
`timescale 1ns/1ns
module la_tb;

  localparam int BUF_DEPTH = 16;
  localparam int NUM_ROWS  = 5;
  localparam int LIMIT     = 400 * NUM_ROWS;  // cycles for the whole run

  // one capture run with the counts the DUT is expected to use
  typedef struct packed {
    logic          set_cnt;   // 0 leaves the reset counts in place
    int            rd_cnt;
    int            dly_cnt;
    la_pkg::smpl_t trg_val;
    la_pkg::smpl_t trg_mask;
    int            n_pre;     // forced match is sample index n_pre
  } row_t;

  logic           clk_i;
  logic           rst_in;
  logic           cmd_stb_i;
  la_pkg::cmd_t   cmd_i;
  logic           smpl_stb_i;
  la_pkg::smpl_t  smpl_i;
  logic           byte_stb_o;
  la_pkg::byte_t  byte_o;
  logic           busy_o;
  logic           done_o;

  row_t           rows [NUM_ROWS];
  la_pkg::smpl_t  rec_q[$];      // samples the buffer should hold for this run
  la_pkg::byte_t  rx_q[$];       // every byte seen on the output
  int             done_cnt = 0;
  int             cycles = 0;

  la_top #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_la_top (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cmd_stb_i  (cmd_stb_i),
    .cmd_i      (cmd_i),
    .smpl_stb_i (smpl_stb_i),
    .smpl_i     (smpl_i),
    .byte_stb_o (byte_stb_o),
    .byte_o     (byte_o),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  always #4 clk_i = ~clk_i;

  // collect output bytes and done pulses
  always @(negedge clk_i) begin
    if (byte_stb_o) begin
      rx_q.push_back(byte_o);
    end
    if (done_o) begin
      done_cnt <= done_cnt + 1;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("ERROR: run did not finish within %0d cycles", LIMIT);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  task automatic compare_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("MISMATCH time %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR time %0t: %s", $time, what);
      $display("Checks failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic issue_cmd(input la_pkg::cmd_t cmd);
    cmd_stb_i = 1'b1;
    cmd_i     = cmd;
    next_cycle();
    cmd_stb_i = 1'b0;
    next_cycle();
  endtask

  // one strobe every 3 cycles
  task automatic strobe_sample(input la_pkg::smpl_t s);
    smpl_stb_i = 1'b1;
    smpl_i     = s;
    next_cycle();
    smpl_stb_i = 1'b0;
    next_cycle();
    next_cycle();
  endtask

  function automatic la_pkg::smpl_t miss_sample(input row_t row, input int i);
    la_pkg::smpl_t s;
    s = la_pkg::smpl_t'($urandom());
    if (i % 2 == 1) begin
      s = (row.trg_val & ~row.trg_mask) | (s & row.trg_mask);  // equal on don't-care bits
    end
    if (((s ^ row.trg_val) & row.trg_mask) == '0) begin
      s = s ^ (row.trg_mask & (~row.trg_mask + 1'b1));  // break lowest compared bit
    end
    return s;
  endfunction

  function automatic la_pkg::smpl_t hit_sample(input row_t row);
    la_pkg::smpl_t s;
    s = (row.trg_val & row.trg_mask) | (la_pkg::smpl_t'($urandom()) & ~row.trg_mask);
    if (((s ^ row.trg_val) & ~row.trg_mask) == '0) begin
      s = s ^ (~row.trg_mask & (row.trg_mask + 1'b1));  // lowest don't-care bit differs
    end
    return s;
  endfunction

  task automatic run_row(input row_t row);
    la_pkg::cmd_t   cmd;
    la_pkg::smpl_t  s;
    la_pkg::smpl_t  exp_s;
    int             rx_base;
    int             done_base;
    rec_q.delete();
    rx_base   = rx_q.size();
    done_base = done_cnt;
    if (row.set_cnt) begin
      cmd        = '0;
      cmd[31:30] = la_pkg::CMD_SET_CNT;
      cmd[23:12] = 12'(row.rd_cnt);
      cmd[11:0]  = 12'(row.dly_cnt);
      issue_cmd(cmd);
    end
    cmd        = '0;
    cmd[31:30] = la_pkg::CMD_SET_VAL;
    cmd[15:0]  = row.trg_val;
    issue_cmd(cmd);
    cmd[31:30] = la_pkg::CMD_SET_MASK;
    cmd[15:0]  = row.trg_mask;
    issue_cmd(cmd);
    cmd        = '0;
    cmd[31:30] = la_pkg::CMD_ARM;
    issue_cmd(cmd);
    next_cycle();
    for (int i = 0; i < row.n_pre; i++) begin
      s = miss_sample(row, i);
      strobe_sample(s);
      rec_q.push_back(s);
      require(!busy_o, "trigger fired on a non-matching sample");
    end
    s = hit_sample(row);
    strobe_sample(s);
    rec_q.push_back(s);
    require(busy_o, "trigger did not fire on the matching sample");
    for (int i = 0; i < row.dly_cnt; i++) begin
      s = la_pkg::smpl_t'($urandom());
      strobe_sample(s);
      rec_q.push_back(s);
    end
    for (int i = 0; i < 4; i++) begin
      strobe_sample(la_pkg::smpl_t'($urandom()));  // must be dropped
    end
    while (done_cnt == done_base) begin
      next_cycle();
    end
    repeat (3) next_cycle();
    compare_value("done_o pulses", done_cnt - done_base, 1);
    compare_value("byte_stb_o count", rx_q.size() - rx_base, 2 * row.rd_cnt);
    for (int w = 0; w < row.rd_cnt; w++) begin
      exp_s = rec_q[rec_q.size() - row.rd_cnt + w];  // oldest first
      compare_value("byte_o", int'(rx_q[rx_base + 2 * w]), int'(exp_s[15:8]));
      compare_value("byte_o", int'(rx_q[rx_base + 2 * w + 1]), int'(exp_s[7:0]));
    end
    // spent trigger keeps quiet on a new match
    rx_base = rx_q.size();
    strobe_sample(hit_sample(row));
    repeat (8) begin
      next_cycle();
      require(!busy_o, "capture started again without a new arm");
    end
    compare_value("byte_stb_o count", rx_q.size() - rx_base, 0);
  endtask

  initial begin
    void'($urandom(32'hd7e9));
    clk_i      = 1'b0;
    rst_in     = 1'b0;
    cmd_stb_i  = 1'b0;
    cmd_i      = '0;
    smpl_stb_i = 1'b0;
    smpl_i     = '0;
    // first row relies on the reset counts of 1 and 1
    rows[0] = '{set_cnt: 1'b0, rd_cnt: 1, dly_cnt: 1, trg_val: 16'h00a5,
                trg_mask: 16'hffff, n_pre: 4};
    rows[1] = '{set_cnt: 1'b1, rd_cnt: 4, dly_cnt: 2, trg_val: 16'h1234,
                trg_mask: 16'hffff, n_pre: 5};
    rows[2] = '{set_cnt: 1'b1, rd_cnt: 6, dly_cnt: 3, trg_val: 16'hbe00,
                trg_mask: 16'hff00, n_pre: 8};
    rows[3] = '{set_cnt: 1'b1, rd_cnt: BUF_DEPTH, dly_cnt: 3, trg_val: 16'h0f0f,
                trg_mask: 16'h0ff0, n_pre: 20};  // pointer wraps
    rows[4] = '{set_cnt: 1'b1, rd_cnt: 3, dly_cnt: 5, trg_val: 16'h8001,
                trg_mask: 16'h8001, n_pre: 4};
    repeat (5) @(posedge clk_i);
    #1;
    rst_in = 1'b1;
    next_cycle();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: rtl/la_top.sv
// top level of the capture core, connects config, trigger, FSM, buffer and serializer
`timescale 1ns/1ns
module la_top #(
  parameter int BUF_DEPTH = 16
) (
  input  logic           clk_i,
  input  logic           rst_in,
  input  logic           cmd_stb_i,
  input  la_pkg::cmd_t   cmd_i,
  input  logic           smpl_stb_i,
  input  la_pkg::smpl_t  smpl_i,
  output logic           byte_stb_o,
  output la_pkg::byte_t  byte_o,
  output logic           busy_o,
  output logic           done_o
);

  la_pkg::la_cfg_t  cfg;
  logic             arm;
  logic             trg;
  logic             wr_en;
  logic             rd_start;
  logic             rd_en;
  la_pkg::smpl_t    rd_data;
  logic             tx_stb;
  la_pkg::smpl_t    tx_data;
  logic             tx_rdy;

  la_cfg_regs u_cfg_regs (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .cmd_stb_i (cmd_stb_i),
    .cmd_i     (cmd_i),
    .cfg_o     (cfg),
    .arm_o     (arm)
  );

  la_trigger u_trigger (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .arm_i      (arm),
    .smpl_stb_i (smpl_stb_i),
    .smpl_i     (smpl_i),
    .cfg_i      (cfg),
    .trg_o      (trg)
  );

  la_ctrl #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_ctrl (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cfg_i      (cfg),
    .trg_i      (trg),
    .smpl_stb_i (smpl_stb_i),
    .wr_en_o    (wr_en),
    .rd_start_o (rd_start),
    .rd_en_o    (rd_en),
    .rd_data_i  (rd_data),
    .tx_rdy_i   (tx_rdy),
    .tx_stb_o   (tx_stb),
    .tx_data_o  (tx_data),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  la_sample_buf #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_sample_buf (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .wr_en_i    (wr_en),
    .smpl_i     (smpl_i),
    .cfg_i      (cfg),
    .rd_start_i (rd_start),
    .rd_en_i    (rd_en),
    .rd_data_o  (rd_data)
  );

  la_tx_serial u_tx_serial (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .tx_stb_i   (tx_stb),
    .tx_data_i  (tx_data),
    .tx_rdy_o   (tx_rdy),
    .byte_stb_o (byte_stb_o),
    .byte_o     (byte_o)
  );

endmodule

// File: rtl/la_tx_serial.sv
// sample to byte serializer, high byte first on consecutive cycles
`timescale 1ns/1ns
module la_tx_serial (
  input  logic           clk_i,
  input  logic           rst_in,
  input  logic           tx_stb_i,
  input  la_pkg::smpl_t  tx_data_i,
  output logic           tx_rdy_o,
  output logic           byte_stb_o,
  output la_pkg::byte_t  byte_o
);

  localparam int BYTES = la_pkg::SMPL_WIDTH / la_pkg::BYTE_WIDTH;

  la_pkg::smpl_t  shreg;  // remaining bytes, next one on top
  logic [1:0]     bcnt;   // bytes still to send

  assign tx_rdy_o   = (bcnt == '0);
  assign byte_stb_o = (bcnt != '0);
  assign byte_o     = shreg[la_pkg::SMPL_WIDTH-1 -: la_pkg::BYTE_WIDTH];

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      bcnt <= '0;
    end else if (tx_stb_i && tx_rdy_o) begin
      bcnt <= 2'(BYTES);
    end else if (bcnt != '0) begin
      bcnt <= bcnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_stb_i && tx_rdy_o) begin
      shreg <= tx_data_i;
    end else if (bcnt != '0) begin
      shreg <= shreg << la_pkg::BYTE_WIDTH;
    end
  end

endmodule

// File: rtl/la_sample_buf.sv
// circular sample memory, readout starts rd_cnt entries behind the write pointer
`timescale 1ns/1ns
module la_sample_buf #(
  parameter int BUF_DEPTH = 16
) (
  input  logic             clk_i,
  input  logic             rst_in,
  input  logic             wr_en_i,
  input  la_pkg::smpl_t    smpl_i,
  input  la_pkg::la_cfg_t  cfg_i,
  input  logic             rd_start_i,
  input  logic             rd_en_i,
  output la_pkg::smpl_t    rd_data_o
);

  localparam int PTR_W = $clog2(BUF_DEPTH);

  la_pkg::smpl_t     mem [BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;   // next entry to write
  logic [PTR_W-1:0]  rd_ptr;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      wr_ptr <= '0;
    end else if (wr_en_i) begin
      wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_ptr] <= smpl_i;
    end
  end

  // rd_cnt equal to the depth gives rd_ptr == wr_ptr, the oldest entry
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rd_ptr <= '0;
    end else if (rd_start_i) begin
      rd_ptr <= wr_ptr - cfg_i.rd_cnt[PTR_W-1:0];
    end else if (rd_en_i) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_ptr];
    end
  end

endmodule

// File: rtl/la_ctrl.sv
// capture FSM gating sample writes, counting the post-trigger delay and pacing the readout
`timescale 1ns/1ns
module la_ctrl #(
  parameter int BUF_DEPTH = 16
) (
  input  logic             clk_i,
  input  logic             rst_in,
  input  la_pkg::la_cfg_t  cfg_i,
  input  logic             trg_i,
  input  logic             smpl_stb_i,
  output logic             wr_en_o,
  output logic             rd_start_o,
  output logic             rd_en_o,
  input  la_pkg::smpl_t    rd_data_i,
  input  logic             tx_rdy_i,
  output logic             tx_stb_o,
  output la_pkg::smpl_t    tx_data_o,
  output logic             busy_o,
  output logic             done_o
);

  localparam la_pkg::cnt_t DEPTH_CNT = la_pkg::cnt_t'(BUF_DEPTH);

  typedef enum logic [2:0] {
    IDLE,
    TRG,
    TX,
    LOAD,
    TX_WAIT
  } state_e;

  state_e        state;
  state_e        state_nxt;
  la_pkg::cnt_t  cnt;       // post-trigger writes, then words read
  la_pkg::cnt_t  cnt_nxt;
  la_pkg::cnt_t  rd_lim;
  logic          last_word;

  // never read more words than the buffer holds
  assign rd_lim    = (cfg_i.rd_cnt > DEPTH_CNT) ? DEPTH_CNT : cfg_i.rd_cnt;
  assign last_word = (cnt == rd_lim);
  assign busy_o    = (state != IDLE);

  always_comb begin
    state_nxt  = state;
    cnt_nxt    = cnt;
    wr_en_o    = 1'b0;
    rd_start_o = 1'b0;
    rd_en_o    = 1'b0;
    case (state)
      IDLE: begin
        wr_en_o = smpl_stb_i;
        if (trg_i) begin
          state_nxt = TRG;
          cnt_nxt   = '0;
        end
      end
      TRG: begin
        if (cnt == cfg_i.dly_cnt) begin
          state_nxt  = TX;
          cnt_nxt    = '0;
          rd_start_o = 1'b1;  // last write was at least a cycle ago
        end else if (smpl_stb_i) begin
          wr_en_o = 1'b1;
          cnt_nxt = cnt + 1'b1;
        end
      end
      TX: begin
        if (last_word) begin
          state_nxt = IDLE;
        end else begin
          rd_en_o   = 1'b1;
          cnt_nxt   = cnt + 1'b1;
          state_nxt = LOAD;
        end
      end
      LOAD: begin
        state_nxt = TX_WAIT;  // rd_data_i valid here
      end
      TX_WAIT: begin
        // tx_rdy only drops the cycle after the strobe
        if (tx_rdy_i && !tx_stb_o) begin
          state_nxt = TX;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      cnt      <= '0;
      tx_stb_o <= 1'b0;
      done_o   <= 1'b0;
    end else begin
      state    <= state_nxt;
      cnt      <= cnt_nxt;
      tx_stb_o <= (state == LOAD);
      done_o   <= (state == TX) && last_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == LOAD) begin
      tx_data_o <= rd_data_i;  // held for the serializer
    end
  end

endmodule

// File: rtl/la_trigger.sv
// single-shot masked value trigger, fires one cycle after an armed matching sample
`timescale 1ns/1ns
module la_trigger (
  input  logic             clk_i,
  input  logic             rst_in,
  input  logic             arm_i,
  input  logic             smpl_stb_i,
  input  la_pkg::smpl_t    smpl_i,
  input  la_pkg::la_cfg_t  cfg_i,
  output logic             trg_o
);

  logic armed;
  logic match;
  logic fire;

  // only the masked bits are compared
  assign match = ((smpl_i ^ cfg_i.trg_val) & cfg_i.trg_mask) == '0;
  assign fire  = armed && smpl_stb_i && match;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      armed <= 1'b0;
      trg_o <= 1'b0;
    end else begin
      trg_o <= fire;
      if (arm_i) begin
        armed <= 1'b1;  // new arm wins over a firing in the same cycle
      end else if (fire) begin
        armed <= 1'b0;  // one shot per arm
      end
    end
  end

endmodule

// File: rtl/la_cfg_regs.sv
// command decoder holding the capture configuration and issuing the arm pulse
`timescale 1ns/1ns
module la_cfg_regs (
  input  logic             clk_i,
  input  logic             rst_in,
  input  logic             cmd_stb_i,
  input  la_pkg::cmd_t     cmd_i,
  output la_pkg::la_cfg_t  cfg_o,
  output logic             arm_o
);

  la_pkg::cmd_op_e op;

  assign op = la_pkg::cmd_op_e'(cmd_i[la_pkg::CMD_OP_MSB:la_pkg::CMD_OP_LSB]);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      cfg_o.rd_cnt   <= la_pkg::cnt_t'(1);
      cfg_o.dly_cnt  <= la_pkg::cnt_t'(1);
      cfg_o.trg_val  <= '0;
      cfg_o.trg_mask <= '0;
      arm_o          <= 1'b0;
    end else begin
      arm_o <= 1'b0;  // arm is a single-cycle pulse
      if (cmd_stb_i) begin
        case (op)
          la_pkg::CMD_SET_CNT: begin
            cfg_o.rd_cnt  <= cmd_i[la_pkg::CMD_RD_LSB +: la_pkg::CNT_WIDTH];
            cfg_o.dly_cnt <= cmd_i[la_pkg::CMD_DLY_LSB +: la_pkg::CNT_WIDTH];
          end
          la_pkg::CMD_SET_VAL: begin
            cfg_o.trg_val <= cmd_i[la_pkg::CMD_DATA_LSB +: la_pkg::SMPL_WIDTH];
          end
          la_pkg::CMD_SET_MASK: begin
            cfg_o.trg_mask <= cmd_i[la_pkg::CMD_DATA_LSB +: la_pkg::SMPL_WIDTH];
          end
          default: begin
            arm_o <= 1'b1;  // CMD_ARM
          end
        endcase
      end
    end
  end

endmodule

// File: rtl/la_pkg.sv
// shared widths, types, command opcodes and config struct of the capture core, used by scoped names
package la_pkg;

  localparam int SMPL_WIDTH = 16;  // one sample is two bytes
  localparam int CMD_WIDTH  = 32;
  localparam int CNT_WIDTH  = 12;
  localparam int BYTE_WIDTH = 8;

  typedef logic [SMPL_WIDTH-1:0] smpl_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;
  typedef logic [BYTE_WIDTH-1:0] byte_t;
  typedef logic [CMD_WIDTH-1:0]  cmd_t;

  // command word field positions
  localparam int CMD_OP_MSB   = 31;
  localparam int CMD_OP_LSB   = 30;
  localparam int CMD_RD_LSB   = 12;  // readout count at 23:12
  localparam int CMD_DLY_LSB  = 0;   // delay count at 11:0
  localparam int CMD_DATA_LSB = 0;   // value or mask at 15:0

  typedef enum logic [1:0] {
    CMD_SET_CNT  = 2'd0,
    CMD_SET_VAL  = 2'd1,
    CMD_SET_MASK = 2'd2,
    CMD_ARM      = 2'd3
  } cmd_op_e;

  typedef struct packed {
    cnt_t  rd_cnt;    // samples read out after capture
    cnt_t  dly_cnt;   // samples recorded after the trigger
    smpl_t trg_val;
    smpl_t trg_mask;  // 1 = bit takes part in the compare
  } la_cfg_t;

endpackage
